// ==== common/soc_cfg.svh ====
// SoC configuration macros
// Bus widths, region codes of the address map, memory depths
// and register offsets of the interruptor and GPIO blocks

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Upper address nibble per slave
`define REGION_ROM   4'h1
`define REGION_CLINT 4'h2
`define REGION_GPIO  4'h4
`define REGION_RAM   4'h8

// Memory depths in words
`define ROM_WORDS 16
`define RAM_WORDS 256

// Interruptor register map
`define CLINT_MSIP        8'h00
`define CLINT_MTIMECMP_LO 8'h08
`define CLINT_MTIMECMP_HI 8'h0C
`define CLINT_MTIME_LO    8'h10
`define CLINT_MTIME_HI    8'h14

// GPIO register map
`define GPIO_W   8
`define GPIO_LED 8'h00
`define GPIO_SW  8'h04

`endif

// ==== common/soc_pkg.sv ====
// SoC bus types
// APB request and response structs, the address word union
// and the slave enumeration used by the fabric

`include "soc_cfg.svh"

package soc_pkg;

    // Number of slaves behind the fabric
    localparam int unsigned NUM_SLV = 4;

    // Master side of the APB
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] paddr;
        logic                   pwrite;
        logic [`SOC_DATA_W-1:0] pwdata;
        logic                   penable;
    } apb_req_t;

    // Slave side of the APB
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_resp_t;

    // Address word, flat or split into region and offset
    typedef union packed {
        logic [`SOC_ADDR_W-1:0] flat;
        struct packed {
            logic [3:0]             region;
            logic [`SOC_ADDR_W-5:0] offset;
        } fields;
    } soc_addr_u;

    // Slot of each slave in the select and response vectors
    typedef enum logic [1:0] {
        SLV_ROM   = 2'd0,
        SLV_CLINT = 2'd1,
        SLV_GPIO  = 2'd2,
        SLV_RAM   = 2'd3
    } region_e;

endpackage

// ==== source/apb_fabric.sv ====
// Single-master APB fabric
// Region decode, slave select, response mux and error reply
// for unmapped addresses

`include "soc_cfg.svh"

module apb_fabric import soc_pkg::*; (
    input  logic                    clk,
    input  logic                    ndmreset_n,
    input  logic                    psel_i,
    input  apb_req_t                apb_req_i,
    output apb_resp_t               apb_resp_o,
    output logic      [NUM_SLV-1:0] slv_psel_o,
    input  apb_resp_t [NUM_SLV-1:0] slv_resp_i
);

    soc_addr_u addr;
    logic      setup;
    logic      access;

    // Decode of the current address
    logic      hit_d;
    region_e   idx_d;

    // Selection held from the setup cycle
    logic      hit_q;
    region_e   idx_q;

    logic      cur_hit;
    region_e   cur_idx;

    assign addr.flat = apb_req_i.paddr;
    assign setup     = psel_i & ~apb_req_i.penable;
    assign access    = psel_i & apb_req_i.penable;

    always_comb begin
        hit_d = 1'b1;
        idx_d = SLV_ROM;
        case (addr.fields.region)
            `REGION_ROM:   idx_d = SLV_ROM;
            `REGION_CLINT: idx_d = SLV_CLINT;
            `REGION_GPIO:  idx_d = SLV_GPIO;
            `REGION_RAM:   idx_d = SLV_RAM;
            default:       hit_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            hit_q <= 1'b0;
            idx_q <= SLV_ROM;
        end else if (setup) begin
            hit_q <= hit_d;
            idx_q <= idx_d;
        end
    end

    // Live decode in setup, held decode during access
    assign cur_hit = apb_req_i.penable ? hit_q : hit_d;
    assign cur_idx = apb_req_i.penable ? idx_q : idx_d;

    always_comb begin
        slv_psel_o = '0;
        if (psel_i && cur_hit) begin
            slv_psel_o[cur_idx] = 1'b1;
        end
    end

    // --------------------
    // Response path
    // --------------------
    always_comb begin
        apb_resp_o = '0;
        if (access && !hit_q) begin
            // Unmapped region answers at once with an error
            apb_resp_o.pready  = 1'b1;
            apb_resp_o.pslverr = 1'b1;
        end else if (psel_i && cur_hit) begin
            apb_resp_o = slv_resp_i[cur_idx];
        end
    end

endmodule

// ==== source/boot_rom.sv ====
// Boot ROM behind APB
// Word table loaded from a hex image, writes answered with an error

`include "soc_cfg.svh"

module boot_rom import soc_pkg::*; (
    input  logic      clk,
    input  logic      psel_i,
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o
);

    localparam int unsigned ROM_AW = $clog2(`ROM_WORDS);

    logic [`SOC_DATA_W-1:0] rom_q [`ROM_WORDS];
    logic [`SOC_DATA_W-1:0] rdata_q;
    logic [ROM_AW-1:0]      word_idx;
    soc_addr_u              addr;
    logic                   access;

    initial begin
        $readmemh("source/boot_rom.hex", rom_q);
    end

    assign addr.flat = apb_req_i.paddr;
    assign word_idx  = addr.fields.offset[ROM_AW+1:2];
    assign access    = psel_i & apb_req_i.penable;

    // Word fetched in the setup cycle, ready for the first access cycle
    always_ff @(posedge clk) begin
        if (psel_i && !apb_req_i.penable) begin
            rdata_q <= rom_q[word_idx];
        end
    end

    assign apb_resp_o.prdata  = rdata_q;
    assign apb_resp_o.pready  = access;
    assign apb_resp_o.pslverr = access & apb_req_i.pwrite;

endmodule

// ==== source/scratch_ram.sv ====
// Scratch RAM behind APB
// Single-port word memory, registered read and one wait state

`include "soc_cfg.svh"

module scratch_ram import soc_pkg::*; (
    input  logic      clk,
    input  logic      ndmreset_n,
    input  logic      psel_i,
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o
);

    localparam int unsigned RAM_AW = $clog2(`RAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem_q [`RAM_WORDS];
    logic [`SOC_DATA_W-1:0] rdata_q;
    logic [RAM_AW-1:0]      word_idx;
    soc_addr_u              addr;
    logic                   access;
    logic                   wait_q;
    logic                   done;

    assign addr.flat = apb_req_i.paddr;
    // Upper offset bits ignored, so addresses wrap at the depth
    assign word_idx  = addr.fields.offset[RAM_AW+1:2];
    assign access    = psel_i & apb_req_i.penable;
    assign done      = access & wait_q;

    // Wait flag is set in the first access cycle only
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access & ~wait_q;
        end
    end

    // Memory array and read register
    always_ff @(posedge clk) begin
        if (access && !wait_q) begin
            rdata_q <= mem_q[word_idx];
        end
        if (done && apb_req_i.pwrite) begin
            mem_q[word_idx] <= apb_req_i.pwdata;
        end
    end

    assign apb_resp_o.prdata  = rdata_q;
    assign apb_resp_o.pready  = done;
    assign apb_resp_o.pslverr = 1'b0;

endmodule

// ==== clint/clint_timer.sv ====
// Core-local interruptor
// Half-rate tick, 64-bit machine timer and compare register,
// software interrupt bit and registered interrupt outputs

`include "soc_cfg.svh"

module clint_timer import soc_pkg::*; (
    input  logic      clk,
    input  logic      ndmreset_n,
    input  logic      psel_i,
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o,
    output logic      timer_irq_o,
    output logic      ipi_o
);

    soc_addr_u   addr;
    logic [7:0]  reg_off;
    logic        access;
    logic        wr_en;

    logic        rtc_q;
    logic        rtc_prev_q;
    logic        tick;

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        msip_q;
    logic        timer_irq_q;

    assign addr.flat = apb_req_i.paddr;
    assign reg_off   = addr.fields.offset[7:0];
    assign access    = psel_i & apb_req_i.penable;
    assign wr_en     = access & apb_req_i.pwrite;

    // --------------------
    // Real-time tick
    // --------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q      <= 1'b0;
            rtc_prev_q <= 1'b0;
        end else begin
            rtc_q      <= ~rtc_q;
            rtc_prev_q <= rtc_q;
        end
    end

    // Rising edge of the tick
    assign tick = rtc_q & ~rtc_prev_q;

    // --------------------
    // Timer registers
    // --------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
        end else begin
            // Bus write wins over the increment
            if (wr_en && reg_off == `CLINT_MTIME_LO) begin
                mtime_q[31:0] <= apb_req_i.pwdata;
            end else if (wr_en && reg_off == `CLINT_MTIME_HI) begin
                mtime_q[63:32] <= apb_req_i.pwdata;
            end else if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_en && reg_off == `CLINT_MTIMECMP_LO) begin
                mtimecmp_q[31:0] <= apb_req_i.pwdata;
            end
            if (wr_en && reg_off == `CLINT_MTIMECMP_HI) begin
                mtimecmp_q[63:32] <= apb_req_i.pwdata;
            end
            if (wr_en && reg_off == `CLINT_MSIP) begin
                msip_q <= apb_req_i.pwdata[0];
            end
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // Read mux, unknown offsets give zero
    always_comb begin
        apb_resp_o         = '0;
        apb_resp_o.pready  = access;
        case (reg_off)
            `CLINT_MSIP:        apb_resp_o.prdata = {31'd0, msip_q};
            `CLINT_MTIMECMP_LO: apb_resp_o.prdata = mtimecmp_q[31:0];
            `CLINT_MTIMECMP_HI: apb_resp_o.prdata = mtimecmp_q[63:32];
            `CLINT_MTIME_LO:    apb_resp_o.prdata = mtime_q[31:0];
            `CLINT_MTIME_HI:    apb_resp_o.prdata = mtime_q[63:32];
            default:            apb_resp_o.prdata = '0;
        endcase
    end

    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = msip_q;

endmodule

// ==== source/gpio_regs.sv ====
// GPIO block behind APB
// LED output register and synchronized switch inputs

`include "soc_cfg.svh"

module gpio_regs import soc_pkg::*; (
    input  logic               clk,
    input  logic               ndmreset_n,
    input  logic               psel_i,
    input  apb_req_t           apb_req_i,
    output apb_resp_t          apb_resp_o,
    output logic [`GPIO_W-1:0] led_o,
    input  logic [`GPIO_W-1:0] sw_i
);

    soc_addr_u          addr;
    logic [7:0]         reg_off;
    logic               access;
    logic [`GPIO_W-1:0] led_q;
    logic [`GPIO_W-1:0] sw_meta_q;
    logic [`GPIO_W-1:0] sw_sync_q;

    assign addr.flat = apb_req_i.paddr;
    assign reg_off   = addr.fields.offset[7:0];
    assign access    = psel_i & apb_req_i.penable;

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            led_q     <= '0;
            sw_meta_q <= '0;
            sw_sync_q <= '0;
        end else begin
            // Switches are asynchronous to the clock
            sw_meta_q <= sw_i;
            sw_sync_q <= sw_meta_q;
            if (access && apb_req_i.pwrite && reg_off == `GPIO_LED) begin
                led_q <= apb_req_i.pwdata[`GPIO_W-1:0];
            end
        end
    end

    // Read-back, zero-extended to the bus width
    always_comb begin
        apb_resp_o        = '0;
        apb_resp_o.pready = access;
        case (reg_off)
            `GPIO_LED: apb_resp_o.prdata = {{(`SOC_DATA_W-`GPIO_W){1'b0}}, led_q};
            `GPIO_SW:  apb_resp_o.prdata = {{(`SOC_DATA_W-`GPIO_W){1'b0}}, sw_sync_q};
            default:   apb_resp_o.prdata = '0;
        endcase
    end

    assign led_o = led_q;

endmodule

// ==== source/soc_top.sv ====
// SoC top level
// APB fabric with boot ROM, scratch RAM, interruptor and GPIO

`include "soc_cfg.svh"

module soc_top import soc_pkg::*; (
    input  logic              clk,
    input  logic              ndmreset_n,
    input  logic              psel_i,
    input  apb_req_t          apb_req_i,
    output apb_resp_t         apb_resp_o,
    output logic [`GPIO_W-1:0] led_o,
    input  logic [`GPIO_W-1:0] sw_i,
    output logic              timer_irq_o,
    output logic              ipi_o
);

    // Per-slave select bits and responses
    logic      [NUM_SLV-1:0] slv_psel;
    apb_resp_t [NUM_SLV-1:0] slv_resp;

    // --------------------
    // Fabric
    // --------------------
    apb_fabric i_apb_fabric (
        .clk        ( clk        ),
        .ndmreset_n ( ndmreset_n ),
        .psel_i     ( psel_i     ),
        .apb_req_i  ( apb_req_i  ),
        .apb_resp_o ( apb_resp_o ),
        .slv_psel_o ( slv_psel   ),
        .slv_resp_i ( slv_resp   )
    );

    // --------------------
    // Memories
    // --------------------
    boot_rom i_boot_rom (
        .clk        ( clk                ),
        .psel_i     ( slv_psel[SLV_ROM]  ),
        .apb_req_i  ( apb_req_i          ),
        .apb_resp_o ( slv_resp[SLV_ROM]  )
    );

    // Stands in for the board memory
    scratch_ram i_scratch_ram (
        .clk        ( clk                ),
        .ndmreset_n ( ndmreset_n         ),
        .psel_i     ( slv_psel[SLV_RAM]  ),
        .apb_req_i  ( apb_req_i          ),
        .apb_resp_o ( slv_resp[SLV_RAM]  )
    );

    // --------------------
    // Peripherals
    // --------------------
    clint_timer i_clint_timer (
        .clk         ( clk                 ),
        .ndmreset_n  ( ndmreset_n          ),
        .psel_i      ( slv_psel[SLV_CLINT] ),
        .apb_req_i   ( apb_req_i           ),
        .apb_resp_o  ( slv_resp[SLV_CLINT] ),
        .timer_irq_o ( timer_irq_o         ),
        .ipi_o       ( ipi_o               )
    );

    gpio_regs i_gpio_regs (
        .clk        ( clk                ),
        .ndmreset_n ( ndmreset_n         ),
        .psel_i     ( slv_psel[SLV_GPIO] ),
        .apb_req_i  ( apb_req_i          ),
        .apb_resp_o ( slv_resp[SLV_GPIO] ),
        .led_o      ( led_o              ),
        .sw_i       ( sw_i               )
    );

endmodule

// ==== test/tb_soc.sv ====
// SoC testbench
// Clock, reset, watchdog, APB master tasks and directed tests
// for boot ROM, scratch RAM, GPIO, interruptor and unmapped space

`include "soc_cfg.svh"

module tb_soc import soc_pkg::*; ();

    localparam logic [31:0] ROM_BASE   = {`REGION_ROM, 28'h0};
    localparam logic [31:0] CLINT_BASE = {`REGION_CLINT, 28'h0};
    localparam logic [31:0] GPIO_BASE  = {`REGION_GPIO, 28'h0};
    localparam logic [31:0] RAM_BASE   = {`REGION_RAM, 28'h0};
    localparam logic [31:0] HOLE_BASE  = {4'h3, 28'h0};

    logic               clk;
    logic               ndmreset_n;
    logic               psel;
    apb_req_t           apb_req;
    apb_resp_t          apb_resp;
    logic [`GPIO_W-1:0] led;
    logic [`GPIO_W-1:0] sw;
    logic               timer_irq;
    logic               ipi;

    int          errors    = 0;
    int          tests_run = 0;
    int          cycle_cnt = 0;
    logic [31:0] rom_exp [`ROM_WORDS];
    logic [31:0] ram_exp [32];

    soc_top dut0 (
        .clk         ( clk        ),
        .ndmreset_n  ( ndmreset_n ),
        .psel_i      ( psel       ),
        .apb_req_i   ( apb_req    ),
        .apb_resp_o  ( apb_resp   ),
        .led_o       ( led        ),
        .sw_i        ( sw         ),
        .timer_irq_o ( timer_irq  ),
        .ipi_o       ( ipi        )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Watchdog, well above the length of all tests
    initial begin
        #20000;
        $display("Timeout: the tests did not finish within 20000 time units");
        $display("Done: errors found");
        $finish;
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    // --------------------
    // APB master
    // --------------------
    task automatic apb_transfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        // Setup cycle
        @(posedge clk);
        #1;
        psel           = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwrite = wr;
        apb_req.pwdata = wdata;
        apb_req.penable = 1'b0;
        // Access cycles until ready
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_resp.pready) begin
            @(negedge clk);
        end
        rdata = apb_resp.prdata;
        err   = apb_resp.pslverr;
        @(posedge clk);
        #1;
        psel            = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(addr, 1'b0, 32'h0, data, err);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic reset_state_test();
        logic [31:0] v;
        logic        err;
        tests_run++;
        if (led !== 8'h00) report_fail($sformatf("LEDs 0x%02h after reset", led));
        if (timer_irq !== 1'b0 || ipi !== 1'b0) report_fail("interrupt high after reset");
        if (apb_resp.pready !== 1'b0) report_fail("ready high on an idle bus after reset");
        apb_read(CLINT_BASE + 32'(`CLINT_MTIME_LO), v, err);
        if (err || v > 32'd64) report_fail($sformatf("mtime 0x%08h after reset", v));
        apb_read(CLINT_BASE + 32'(`CLINT_MTIMECMP_LO), v, err);
        if (v !== 32'hffff_ffff) report_fail($sformatf("mtimecmp low 0x%08h", v));
    endtask

    task automatic boot_rom_test();
        logic [31:0] v;
        logic        err;
        tests_run++;
        $readmemh("source/boot_rom.hex", rom_exp);
        for (int i = 0; i < `ROM_WORDS; i++) begin
            apb_read(ROM_BASE + 32'(i * 4), v, err);
            if (err || v !== rom_exp[i]) begin
                report_fail($sformatf("ROM word %0d is 0x%08h, expected 0x%08h", i, v, rom_exp[i]));
            end
        end
        apb_write(ROM_BASE + 32'h0c, 32'h1234_5678, err);
        if (err !== 1'b1) report_fail("ROM write gave no error");
        apb_read(ROM_BASE + 32'h0c, v, err);
        if (v !== rom_exp[3]) report_fail($sformatf("ROM word 3 changed to 0x%08h", v));
    endtask

    task automatic scratch_ram_test();
        logic [31:0] v;
        logic        err;
        tests_run++;
        // Spread over the array, word 0 included
        for (int i = 0; i < 32; i++) begin
            ram_exp[i] = $urandom;
            apb_write(RAM_BASE + 32'(i * 7 * 4), ram_exp[i], err);
            if (err) report_fail($sformatf("RAM write %0d gave an error", i));
        end
        for (int i = 0; i < 32; i++) begin
            apb_read(RAM_BASE + 32'(i * 7 * 4), v, err);
            if (err || v !== ram_exp[i]) begin
                report_fail($sformatf("RAM word %0d is 0x%08h, expected 0x%08h",
                                      i * 7, v, ram_exp[i]));
            end
        end
        // One word past the end lands on word 0
        apb_read(RAM_BASE + 32'(`RAM_WORDS * 4), v, err);
        if (v !== ram_exp[0]) report_fail($sformatf("RAM alias read 0x%08h", v));
        ram_exp[0] = $urandom;
        apb_write(RAM_BASE + 32'(`RAM_WORDS * 4), ram_exp[0], err);
        apb_read(RAM_BASE, v, err);
        if (v !== ram_exp[0]) report_fail($sformatf("RAM word 0 after alias write 0x%08h", v));
    endtask

    task automatic gpio_test();
        logic [31:0] v;
        logic        err;
        tests_run++;
        apb_write(GPIO_BASE + 32'(`GPIO_LED), 32'h0000_00a5, err);
        if (led !== 8'ha5) report_fail($sformatf("LEDs show 0x%02h", led));
        apb_read(GPIO_BASE + 32'(`GPIO_LED), v, err);
        if (err || v !== 32'h0000_00a5) report_fail($sformatf("LED read-back 0x%08h", v));
        sw = 8'h3c;
        repeat (4) @(posedge clk);
        #1;
        apb_read(GPIO_BASE + 32'(`GPIO_SW), v, err);
        if (v !== 32'h0000_003c) report_fail($sformatf("switches read 0x%08h", v));
        // Switch register is read-only
        apb_write(GPIO_BASE + 32'(`GPIO_SW), 32'h0000_00ff, err);
        apb_read(GPIO_BASE + 32'(`GPIO_SW), v, err);
        if (v !== 32'h0000_003c) report_fail($sformatf("switches after write 0x%08h", v));
    endtask

    task automatic interruptor_test();
        logic [31:0] v;
        logic [31:0] t0;
        logic        err;
        int          start;
        tests_run++;
        apb_write(CLINT_BASE + 32'(`CLINT_MSIP), 32'h1, err);
        if (ipi !== 1'b1) report_fail("ipi_o low with MSIP set");
        apb_write(CLINT_BASE + 32'(`CLINT_MSIP), 32'h0, err);
        if (ipi !== 1'b0) report_fail("ipi_o high with MSIP clear");

        apb_write(CLINT_BASE + 32'(`CLINT_MTIME_LO), 32'h0, err);
        apb_write(CLINT_BASE + 32'(`CLINT_MTIME_HI), 32'h0, err);
        apb_write(CLINT_BASE + 32'(`CLINT_MTIMECMP_HI), 32'h0, err);
        apb_write(CLINT_BASE + 32'(`CLINT_MTIMECMP_LO), 32'd40, err);
        start = cycle_cnt;
        while (!timer_irq && (cycle_cnt - start) < 200) begin
            apb_read(CLINT_BASE + 32'(`CLINT_MTIME_LO), v, err);
            // Interrupt reflects the value just read
            if (v < 32'd40 && timer_irq) report_fail($sformatf("timer_irq_o high at mtime %0d", v));
        end
        if (!timer_irq) begin
            report_fail("timer_irq_o did not rise within 200 cycles");
        end
        apb_read(CLINT_BASE + 32'(`CLINT_MTIME_LO), v, err);
        if (v < 32'd40) report_fail($sformatf("mtime %0d with interrupt pending", v));

        apb_write(CLINT_BASE + 32'(`CLINT_MTIMECMP_HI), 32'hffff_ffff, err);
        @(posedge clk);
        #1;
        if (timer_irq) report_fail("timer_irq_o still high after raising mtimecmp");

        apb_read(CLINT_BASE + 32'(`CLINT_MTIME_LO), t0, err);
        repeat (10) @(posedge clk);
        apb_read(CLINT_BASE + 32'(`CLINT_MTIME_LO), v, err);
        if (v < t0) report_fail($sformatf("mtime went back from %0d to %0d", t0, v));
    endtask

    task automatic unmapped_test();
        logic [31:0] v;
        logic        err;
        tests_run++;
        apb_read(HOLE_BASE, v, err);
        if (err !== 1'b1 || v !== 32'h0) begin
            report_fail($sformatf("unmapped read gave err %0b data 0x%08h", err, v));
        end
        apb_write(HOLE_BASE, 32'hdead_beef, err);
        if (err !== 1'b1) report_fail("unmapped write gave no error");
        apb_read(RAM_BASE, v, err);
        if (v !== ram_exp[0]) report_fail($sformatf("RAM word 0 changed to 0x%08h", v));
        apb_read(GPIO_BASE + 32'(`GPIO_LED), v, err);
        if (v !== 32'h0000_00a5) report_fail($sformatf("LED register changed to 0x%08h", v));
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int unsigned seed;
        seed            = $urandom(32'h9fcb);
        ndmreset_n      = 1'b0;
        psel            = 1'b0;
        apb_req.paddr   = '0;
        apb_req.pwrite  = 1'b0;
        apb_req.pwdata  = '0;
        apb_req.penable = 1'b0;
        sw              = '0;
        repeat (8) @(posedge clk);
        #1;
        ndmreset_n = 1'b1;

        reset_state_test();
        boot_rom_test();
        scratch_ram_test();
        gpio_test();
        interruptor_test();
        unmapped_test();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/soc_pkg.sv
source/apb_fabric.sv
source/boot_rom.sv
source/scratch_ram.sv
clint/clint_timer.sv
source/gpio_regs.sv
source/soc_top.sv
test/tb_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f flist.f --top-module tb_soc -o tb_soc > build.log 2>&1 \
    && ./obj_dir/tb_soc > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0

// ==== source/boot_rom.hex ====
// Boot ROM image: one 32-bit hex word per line
// Lines in word order, first line at ROM offset 0x0
00000297
02028593
f1402573
0182a283
00028067
80000537
00050067
10500073
ff9ff06f
00100093
00208113
003101b3
40418233
0000100f
30200073
0000006f
